/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module memFrontEndTb

sim:
	verilator --binary --timing --assert -f sources.f --top-module memFrontEndTb -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* rtl/addressSelect.sv */
`timescale 1ns/1ns

module addressSelect #(
	parameter int AddrWidth = 16
) (
	input  logic                     fetch,
	input  cpuBusPkg::addrSelT       addrSel,
	input  logic [AddrWidth-1:0]     pcA,
	input  logic [AddrWidth-1:0]     aluR,
	input  logic [AddrWidth-1:0]     aluBData,
	input  logic [AddrWidth-1:0]     here,
	input  logic [AddrWidth-1:0]     debugMa,
	output logic [AddrWidth-1:0]     addr
);

	logic [AddrWidth-1:0] execAddr;	// Source picked for execute and commit

	always_comb begin
		case (addrSel)
			cpuBusPkg::AddrPc:    execAddr = pcA;
			cpuBusPkg::AddrAluR:  execAddr = aluR;
			cpuBusPkg::AddrAluB:  execAddr = aluBData;
			cpuBusPkg::AddrHere:  execAddr = here;
			cpuBusPkg::AddrDebug: execAddr = debugMa;	// Monitor selects like any source
			default:              execAddr = pcA;
		endcase
	end

	// Instruction fetch always uses the program counter
	always_comb begin
		if (fetch)
			addr = pcA;
		else
			addr = execAddr;
	end

endmodule

/* rtl/busController.sv */
`timescale 1ns/1ns

module busController (
	input  logic                CLK,
	input  logic                rst,
	input  logic                fetch,
	input  logic                execute,
	input  logic                commit,
	input  cpuBusPkg::busSeqT   busSeq,
	input  logic                byteMode,
	input  logic                addrLsb,
	output logic                rdN,
	output logic                wrN0,
	output logic                wrN1,
	output logic                highByte
);

	logic dataRead;	// Data read pending for commit
	logic isWrite;
	logic lane0En;
	logic lane1En;

	// Lane enables for the request seen in execute
	assign isWrite = (busSeq == cpuBusPkg::SeqWrite);
	assign lane0En = !byteMode || !addrLsb;
	assign lane1En = !byteMode || addrLsb;

	always_ff @(posedge CLK) begin
		if (rst) begin
			dataRead <= 1'b0;
			wrN0     <= 1'b1;
			wrN1     <= 1'b1;
			highByte <= 1'b0;
		end else if (execute) begin
			dataRead <= (busSeq == cpuBusPkg::SeqRead);
			wrN0     <= !(isWrite && lane0En);
			wrN1     <= !(isWrite && lane1En);
			highByte <= byteMode && addrLsb;	// Odd byte sits in the upper lane
		end else if (commit) begin
			dataRead <= 1'b0;
			wrN0     <= 1'b1;
			wrN1     <= 1'b1;
			highByte <= 1'b0;
		end
	end

	// Read strobe covers instruction fetch and the data read in commit
	assign rdN = !(fetch || dataRead);

	rdWrExclusive: assert property (@(posedge CLK) disable iff (rst)
		!(!rdN && (!wrN0 || !wrN1)));

	// Writes only ever land in the commit phase
	wrOnlyInCommit: assert property (@(posedge CLK) disable iff (rst)
		(!wrN0 || !wrN1) |-> commit);

endmodule

/* rtl/cpuBusPkg.sv */
package cpuBusPkg;

	// Two 8-bit lanes make up the data bus
	localparam int DataWidth = 16;
	localparam int LaneWidth = DataWidth / 2;

	// Sequencer state, one instruction is four phases
	typedef enum logic [2:0] {
		Stopped = 3'd0,	// Halted, in debug or in reset
		Fetch   = 3'd1,	// PC on the bus, instruction latched
		Decode  = 3'd2,
		Execute = 3'd3,	// Bus request sampled at the end
		Commit  = 3'd4	// Data strobes active
	} phaseT;

	// Memory operation of the current instruction
	typedef enum logic [1:0] {
		SeqNone  = 2'd0,
		SeqRead  = 2'd1,
		SeqWrite = 2'd2
	} busSeqT;

	// Address source during execute and commit
	typedef enum logic [2:0] {
		AddrPc    = 3'd0,
		AddrAluR  = 3'd1,	// ALU result
		AddrAluB  = 3'd2,	// ALU B operand
		AddrHere  = 3'd3,
		AddrDebug = 3'd4	// Monitor address
	} addrSelT;

endpackage

/* rtl/dataLaneSteer.sv */
`timescale 1ns/1ns

module dataLaneSteer (
	input  logic [cpuBusPkg::DataWidth-1:0] regADout,
	input  logic [cpuBusPkg::DataWidth-1:0] din,
	input  logic                            byteMode,
	input  logic                            highByte,
	output logic [cpuBusPkg::DataWidth-1:0] dout,
	output logic [cpuBusPkg::DataWidth-1:0] readData
);

	localparam int Lw = cpuBusPkg::LaneWidth;

	logic [Lw-1:0] laneByte;	// Byte picked from the read bus

	// Write side
	always_comb begin
		if (highByte)
			dout = {regADout[Lw-1:0], {Lw{1'b0}}};	// Low byte moved up
		else
			dout = regADout;
	end

	// Read side
	assign laneByte = highByte ? din[2*Lw-1:Lw] : din[Lw-1:0];

	always_comb begin
		if (byteMode)
			readData = {{Lw{1'b0}}, laneByte};	// Zero-extended byte
		else
			readData = din;
	end

endmodule

/* rtl/memFrontEnd.sv */
`timescale 1ns/1ns

module memFrontEnd #(
	parameter int AddrWidth = 16
) (
	input  logic                            CLK,
	input  logic                            rst,
	input  logic                            halt,
	input  logic                            debugStop,
	input  logic                            debugStepReq,
	input  logic [cpuBusPkg::DataWidth-1:0] din,
	input  cpuBusPkg::addrSelT              addrSel,
	input  cpuBusPkg::busSeqT               busSeq,
	input  logic                            byteMode,
	input  logic [AddrWidth-1:0]            pcA,
	input  logic [AddrWidth-1:0]            aluR,
	input  logic [AddrWidth-1:0]            aluBData,
	input  logic [AddrWidth-1:0]            here,
	input  logic [AddrWidth-1:0]            debugMa,
	input  logic [cpuBusPkg::DataWidth-1:0] regADout,
	output logic                            fetch,
	output logic                            decode,
	output logic                            execute,
	output logic                            commit,
	output logic                            stopped,
	output logic                            debugActive,
	output logic                            debugStepAck,
	output logic                            pcEn,
	output logic [cpuBusPkg::DataWidth-1:0] instruction,
	output logic [AddrWidth-1:0]            addr,
	output logic [cpuBusPkg::DataWidth-1:0] dout,
	output logic [cpuBusPkg::DataWidth-1:0] readData,
	output logic                            rdN,
	output logic                            wrN0,
	output logic                            wrN1,
	output logic                            highByte
);

	phaseSequencer seq0 (
		.CLK(CLK), .rst(rst), .halt(halt), .debugStop(debugStop),
		.debugStepReq(debugStepReq), .din(din),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit),
		.stopped(stopped), .debugActive(debugActive), .debugStepAck(debugStepAck),
		.pcEn(pcEn), .instruction(instruction)
	);

	addressSelect #(.AddrWidth(AddrWidth)) addrSel0 (
		.fetch(fetch), .addrSel(addrSel), .pcA(pcA), .aluR(aluR),
		.aluBData(aluBData), .here(here), .debugMa(debugMa), .addr(addr)
	);

	busController busCtl0 (
		.CLK(CLK), .rst(rst), .fetch(fetch), .execute(execute), .commit(commit),
		.busSeq(busSeq), .byteMode(byteMode),
		.addrLsb(addr[0]),	// Byte lane select
		.rdN(rdN), .wrN0(wrN0), .wrN1(wrN1), .highByte(highByte)
	);

	dataLaneSteer steer0 (
		.regADout(regADout), .din(din), .byteMode(byteMode), .highByte(highByte),
		.dout(dout), .readData(readData)
	);

endmodule

/* rtl/phaseSequencer.sv */
`timescale 1ns/1ns

module phaseSequencer (
	input  logic                             CLK,
	input  logic                             rst,
	input  logic                             halt,
	input  logic                             debugStop,
	input  logic                             debugStepReq,
	input  logic [cpuBusPkg::DataWidth-1:0]  din,
	output logic                             fetch,
	output logic                             decode,
	output logic                             execute,
	output logic                             commit,
	output logic                             stopped,
	output logic                             debugActive,
	output logic                             debugStepAck,
	output logic                             pcEn,
	output logic [cpuBusPkg::DataWidth-1:0]  instruction
);

	cpuBusPkg::phaseT state;
	logic stepPending;	// Step requested, not started yet
	logic stepRun;	// Current instruction is a single step

	assign stopped = (state == cpuBusPkg::Stopped);
	assign fetch   = (state == cpuBusPkg::Fetch);
	assign decode  = (state == cpuBusPkg::Decode);
	assign execute = (state == cpuBusPkg::Execute);
	assign commit  = (state == cpuBusPkg::Commit);
	assign pcEn    = commit;	// PC advances once per instruction

	always_ff @(posedge CLK) begin
		if (rst) begin
			state        <= cpuBusPkg::Stopped;
			debugActive  <= 1'b0;
			debugStepAck <= 1'b0;
			stepPending  <= 1'b0;
			stepRun      <= 1'b0;
		end else begin
			debugStepAck <= 1'b0;
			if (debugStepReq && debugActive)
				stepPending <= 1'b1;
			case (state)
				cpuBusPkg::Stopped: begin
					if (debugActive) begin
						if (!debugStop) begin
							debugActive <= 1'b0;	// Monitor released the CPU
							stepPending <= 1'b0;
						end else if (stepPending) begin
							state       <= cpuBusPkg::Fetch;
							stepPending <= 1'b0;
							stepRun     <= 1'b1;
						end
					end else if (!halt) begin
						state <= cpuBusPkg::Fetch;
					end
				end
				cpuBusPkg::Fetch:   state <= cpuBusPkg::Decode;
				cpuBusPkg::Decode:  state <= cpuBusPkg::Execute;
				cpuBusPkg::Execute: state <= cpuBusPkg::Commit;
				cpuBusPkg::Commit: begin
					if (stepRun) begin
						state        <= cpuBusPkg::Stopped;
						stepRun      <= 1'b0;
						debugStepAck <= 1'b1;	// Pulse right after the step's commit
					end else if (debugStop) begin
						state       <= cpuBusPkg::Stopped;
						debugActive <= 1'b1;
					end else if (halt) begin
						state <= cpuBusPkg::Stopped;
					end else begin
						state <= cpuBusPkg::Fetch;
					end
				end
				default: state <= cpuBusPkg::Stopped;
			endcase
		end
	end

	// Instruction word comes off the bus at the end of fetch
	always_ff @(posedge CLK) begin
		if (fetch)
			instruction <= din;
	end

	phaseOneHot: assert property (@(posedge CLK) disable iff (rst)
		$onehot0({fetch, decode, execute, commit}));

endmodule

/* sources.f */
rtl/cpuBusPkg.sv
rtl/phaseSequencer.sv
rtl/addressSelect.sv
rtl/busController.sv
rtl/dataLaneSteer.sv
rtl/memFrontEnd.sv
testbench/busChecker.sv
testbench/memFrontEndTb.sv

/* testbench/busChecker.sv */
`timescale 1ns/1ns

module busChecker #(
	parameter int AddrWidth = 16
) (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 fetch,
	input  logic                 decode,
	input  logic                 execute,
	input  logic                 commit,
	input  logic                 stopped,
	input  logic                 pcEn,
	input  logic [AddrWidth-1:0] pcA,
	input  logic [AddrWidth-1:0] addr,
	input  logic [15:0]          instruction,
	input  logic                 rdN,
	input  logic                 wrN0,
	input  logic                 wrN1,
	input  logic                 highByte,
	input  logic [15:0]          dout,
	input  logic [15:0]          readData,
	input  logic [1:0]           busSeq,
	input  logic [15:0]          expInstr,
	input  logic [AddrWidth-1:0] expAddr,
	input  logic [15:0]          expDout,
	input  logic                 expWrN0,
	input  logic                 expWrN1,
	input  logic                 expHighByte,
	input  logic [15:0]          expReadData,
	input  logic                 finishReq,
	input  int                   tbErrors,
	output int                   errorCount
);

	localparam int PhStopped = 0;
	localparam int PhFetch   = 1;
	localparam int PhDecode  = 2;
	localparam int PhExecute = 3;
	localparam int PhCommit  = 4;

	logic started = 1'b0;	// Set once the first edge has been seen
	int lastPhase = PhStopped;
	int phase;

	initial errorCount = 0;

	task automatic compareSignal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic reportOrder(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errorCount++;
	endtask

	always @(posedge CLK) started <= 1'b1;

	always @(negedge CLK) begin
		if (started && rst) begin
			compareSignal("stopped", stopped, 1);
			compareSignal("phases", {fetch, decode, execute, commit}, 0);
			compareSignal("pcEn", pcEn, 0);
			compareSignal("rdN", rdN, 1);
			compareSignal("wrN0", wrN0, 1);
			compareSignal("wrN1", wrN1, 1);
			compareSignal("highByte", highByte, 0);
			lastPhase = PhStopped;
		end else if (started) begin
			if (32'(fetch) + 32'(decode) + 32'(execute) + 32'(commit) + 32'(stopped) != 1)
				reportOrder("phase levels are not exactly one of stopped or a phase");
			phase = fetch ? PhFetch : decode ? PhDecode : execute ? PhExecute :
				commit ? PhCommit : PhStopped;
			// Each phase lasts one cycle and follows its predecessor
			if (phase == PhFetch && !(lastPhase == PhCommit || lastPhase == PhStopped))
				reportOrder("fetch did not follow commit or stopped");
			if (phase == PhDecode && lastPhase != PhFetch)
				reportOrder("decode did not follow fetch");
			if (phase == PhExecute && lastPhase != PhDecode)
				reportOrder("execute did not follow decode");
			if (phase == PhCommit && lastPhase != PhExecute)
				reportOrder("commit did not follow execute");
			if (fetch) begin
				compareSignal("addr", addr, pcA);
				compareSignal("rdN", rdN, 0);
			end
			if (decode)
				compareSignal("instruction", instruction, expInstr);
			if (execute)
				compareSignal("addr", addr, expAddr);
			if (commit) begin
				compareSignal("addr", addr, expAddr);
				compareSignal("pcEn", pcEn, 1);
				compareSignal("rdN", rdN, (busSeq == 2'd1) ? 0 : 1);
				compareSignal("wrN0", wrN0, expWrN0);
				compareSignal("wrN1", wrN1, expWrN1);
				compareSignal("highByte", highByte, expHighByte);
				compareSignal("dout", dout, expDout);
				compareSignal("readData", readData, expReadData);
			end else begin
				compareSignal("pcEn", pcEn, 0);
				compareSignal("wrN0", wrN0, 1);
				compareSignal("wrN1", wrN1, 1);
				compareSignal("highByte", highByte, 0);
				if (!fetch)
					compareSignal("rdN", rdN, 1);	// Bus idle
			end
			lastPhase = phase;
		end
	end

	always @(posedge finishReq)
		$display("Errors: checker %0d, testbench %0d, total %0d",
			errorCount, tbErrors, errorCount + tbErrors);

endmodule

/* testbench/busInput.txt */
// addrSel busSeq byteMode pcA aluR aluBData here debugMa regADout din
// expAddr expDout expWrN0 expWrN1 expHighByte expReadData
0 0 0 0100 2000 3000 4000 5000 1234 0000 0100 1234 1 1 0 0000
1 2 0 0102 2002 3002 4002 5002 ABCD 1111 2002 ABCD 0 0 0 1111
2 1 0 0104 2004 3004 4004 5004 0000 BEEF 3004 0000 1 1 0 BEEF
3 2 1 0106 2006 3006 4006 5006 5A3C 0000 4006 5A3C 0 1 0 0000
4 2 1 0108 2008 3008 4008 5009 5A3C 0000 5009 3C00 1 0 1 0000
1 1 1 010A 200A 300A 400A 500A 7777 C3A5 200A 7777 1 1 0 00A5
2 1 1 010C 200C 300B 400C 500C 7777 C3A5 300B 7700 1 1 1 00C3
4 1 0 010E 200E 300E 400E 500C 0000 6789 500C 0000 1 1 0 6789
0 2 0 0110 2010 3010 4010 5010 FEDC 0000 0110 FEDC 0 0 0 0000
3 1 1 0112 2012 3012 4011 5012 1357 9A5B 4011 5700 1 1 1 009A
0 2 1 0113 2014 3014 4014 5014 00FF 0000 0113 FF00 1 0 1 0000
1 0 1 0116 2015 3016 4016 5016 2468 1357 2015 6800 1 1 1 0013

/* testbench/memFrontEndTb.sv */
`timescale 1ns/1ns

module memFrontEndTb;

	localparam int AddrWidth = 16;
	localparam int NumLines  = 12;
	localparam int Fields    = 16;
	localparam int WaitLimit = 20;	// Cycles before a wait gives up

	logic CLK, rst, halt, debugStop, debugStepReq, byteMode;
	logic [15:0] din, regADout;
	cpuBusPkg::addrSelT addrSel;
	cpuBusPkg::busSeqT busSeq;
	logic [AddrWidth-1:0] pcA, aluR, aluBData, here, debugMa;
	logic fetch, decode, execute, commit, stopped, debugActive, debugStepAck, pcEn;
	logic [15:0] instruction, dout, readData;
	logic [AddrWidth-1:0] addr;
	logic rdN, wrN0, wrN1, highByte;

	logic [15:0] stim [0:NumLines*Fields-1];
	logic [15:0] expInstr, expDout, expReadData, lineDin;
	logic [AddrWidth-1:0] expAddr;
	logic expWrN0, expWrN1, expHighByte;
	logic finishReq;
	int tbErrors;
	int chkErrors;

	memFrontEnd #(.AddrWidth(AddrWidth)) dut0 (
		.CLK(CLK), .rst(rst), .halt(halt), .debugStop(debugStop),
		.debugStepReq(debugStepReq), .din(din), .addrSel(addrSel), .busSeq(busSeq),
		.byteMode(byteMode), .pcA(pcA), .aluR(aluR), .aluBData(aluBData), .here(here),
		.debugMa(debugMa), .regADout(regADout), .fetch(fetch), .decode(decode),
		.execute(execute), .commit(commit), .stopped(stopped), .debugActive(debugActive),
		.debugStepAck(debugStepAck), .pcEn(pcEn), .instruction(instruction), .addr(addr),
		.dout(dout), .readData(readData), .rdN(rdN), .wrN0(wrN0), .wrN1(wrN1),
		.highByte(highByte)
	);

	busChecker #(.AddrWidth(AddrWidth)) chk0 (
		.CLK(CLK), .rst(rst), .fetch(fetch), .decode(decode), .execute(execute),
		.commit(commit), .stopped(stopped), .pcEn(pcEn), .pcA(pcA), .addr(addr),
		.instruction(instruction), .rdN(rdN), .wrN0(wrN0), .wrN1(wrN1),
		.highByte(highByte), .dout(dout), .readData(readData), .busSeq(busSeq),
		.expInstr(expInstr), .expAddr(expAddr), .expDout(expDout), .expWrN0(expWrN0),
		.expWrN1(expWrN1), .expHighByte(expHighByte), .expReadData(expReadData),
		.finishReq(finishReq), .tbErrors(tbErrors), .errorCount(chkErrors)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic reportProblem(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		tbErrors++;
	endtask

	function automatic logic levelOf(input int sel);
		case (sel)
			0: return fetch;
			1: return commit;
			2: return stopped;
			default: return !debugActive;
		endcase
	endfunction

	// Polls at the falling edge until the level is high
	task automatic waitForLevel(input int sel, input string what);
		int count;
		count = 0;
		while (!levelOf(sel) && count < WaitLimit) begin
			@(negedge CLK);
			count++;
		end
		if (!levelOf(sel)) begin
			$display("ERROR at %0t: timeout waiting for %s", $time, what);
			$display("TB FAILED");
			$finish;
		end
	endtask

	task automatic applyLine(input int i);
		int b;
		logic [15:0] word;
		b = i * Fields;
		word = 16'hA000 + 16'(i);	// Instruction word served during fetch
		addrSel     <= cpuBusPkg::addrSelT'(stim[b][2:0]);
		busSeq      <= cpuBusPkg::busSeqT'(stim[b+1][1:0]);
		byteMode    <= stim[b+2][0];
		pcA         <= stim[b+3];
		aluR        <= stim[b+4];
		aluBData    <= stim[b+5];
		here        <= stim[b+6];
		debugMa     <= stim[b+7];
		regADout    <= stim[b+8];
		lineDin     <= stim[b+9];
		expAddr     <= stim[b+10];
		expDout     <= stim[b+11];
		expWrN0     <= stim[b+12][0];
		expWrN1     <= stim[b+13][0];
		expHighByte <= stim[b+14][0];
		expReadData <= stim[b+15];
		din         <= word;
		expInstr    <= word;
	endtask

	task automatic checkQuiet(input int cycles);
		repeat (cycles) begin
			@(negedge CLK);
			if (fetch)
				reportProblem("fetch occurred while the core should be stopped");
			if (debugStepAck)
				reportProblem("unexpected debugStepAck pulse");
		end
	endtask

	task automatic runStep();
		int count;
		int nFetch, nDecode, nExecute, nCommit;
		count = 0;
		nFetch = 0;
		nDecode = 0;
		nExecute = 0;
		nCommit = 0;
		@(posedge CLK) debugStepReq <= 1'b1;
		@(posedge CLK) debugStepReq <= 1'b0;
		@(negedge CLK);
		while (!debugStepAck && count < WaitLimit) begin
			nFetch += 32'(fetch);
			nDecode += 32'(decode);
			nExecute += 32'(execute);
			nCommit += 32'(commit);
			@(negedge CLK);
			count++;
		end
		if (!debugStepAck) begin
			$display("ERROR at %0t: timeout waiting for debugStepAck", $time);
			$display("TB FAILED");
			$finish;
		end else begin
			if (nFetch != 1 || nDecode != 1 || nExecute != 1 || nCommit != 1)
				reportProblem("single step did not run exactly one four-phase instruction");
			if (!stopped)
				reportProblem("core not stopped after single step");
			checkQuiet(4);
		end
	endtask

	initial begin
		rst = 1'b1;
		halt = 1'b0;
		debugStop = 1'b0;
		debugStepReq = 1'b0;
		din = '0;
		regADout = '0;
		addrSel = cpuBusPkg::AddrPc;
		busSeq = cpuBusPkg::SeqNone;
		byteMode = 1'b0;
		pcA = '0;
		aluR = '0;
		aluBData = '0;
		here = '0;
		debugMa = '0;
		finishReq = 1'b0;
		tbErrors = 0;
		$readmemh("testbench/busInput.txt", stim);
		repeat (16) @(posedge CLK);
		rst <= 1'b0;
		applyLine(0);

		for (int i = 0; i < NumLines; i++) begin
			waitForLevel(0, "fetch");
			@(posedge CLK) din <= lineDin;	// Data for this instruction's commit
			waitForLevel(1, "commit");
			@(posedge CLK);
			if (i + 1 < NumLines)
				applyLine(i + 1);
			else
				expInstr <= lineDin;	// din stays put from here on
		end

		// Halt at commit, then resume
		halt <= 1'b1;
		@(negedge CLK);
		waitForLevel(1, "commit before halt");
		@(negedge CLK);
		waitForLevel(2, "stopped after halt");
		checkQuiet(6);
		@(posedge CLK) halt <= 1'b0;
		@(negedge CLK);
		waitForLevel(0, "fetch after halt release");

		// Debug stop and two single steps
		@(posedge CLK) debugStop <= 1'b1;
		@(negedge CLK);
		waitForLevel(2, "stopped after debug stop");
		if (!debugActive)
			reportProblem("debugActive did not rise on debug stop");
		checkQuiet(4);
		runStep();
		runStep();
		@(posedge CLK) debugStop <= 1'b0;
		@(negedge CLK);
		waitForLevel(3, "debugActive to clear");
		waitForLevel(0, "fetch after leaving debug");
		waitForLevel(1, "commit after leaving debug");
		repeat (2) @(posedge CLK);

		finishReq = 1'b1;
		#1;
		if (chkErrors + tbErrors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
